//--- design/hssl_macros.svh
// sizes fixed at build time; register addresses must stay below 256 to fit the 8-bit field
`ifndef HSSL_MACROS_SVH
`define HSSL_MACROS_SVH

// --------------------------------------------------------------------------
// packet and table sizes
// --------------------------------------------------------------------------
`define HSSL_KEY_BITS      32
`define HSSL_PLD_BITS      32
`define HSSL_NUM_RREGS     4
`define HSSL_NUM_MREGS     2
`define HSSL_NUM_CHANNELS  2
`define HSSL_NUM_CREGS     4

// key bits 31:16 of a configuration packet
`define HSSL_CFG_PREFIX    16'hFFFF

// --------------------------------------------------------------------------
// register map, array registers take consecutive addresses
// --------------------------------------------------------------------------
`define HSSL_REG_MP_KEY     8'd0
`define HSSL_REG_MP_FMSK    8'd1
`define HSSL_REG_MP_FSFT    8'd3
`define HSSL_REG_RT_KEY     8'd8
`define HSSL_REG_RT_MASK    8'd12
`define HSSL_REG_RT_ROUTE   8'd16
`define HSSL_REG_DROP_WAIT  8'd20
`define HSSL_REG_REPLY_KEY  8'd21

`endif

//--- design/hssl_pkg.sv
// shared types of the core; opcodes 2 and 3 are reserved and the decoder ignores them
`include "hssl_macros.svh"

package hssl_pkg;

  // --------------------------------------------------------------------------
  // packet fields
  // --------------------------------------------------------------------------
  typedef logic [`HSSL_KEY_BITS - 1:0] key_t;
  typedef logic [`HSSL_PLD_BITS - 1:0] pld_t;

  // output channel number
  typedef logic [$clog2(`HSSL_NUM_CHANNELS) - 1:0] route_t;

  // mapper field shift, 0 to 31
  typedef logic [4:0] fsft_t;

  // packet counters wrap at 2^32
  typedef logic [31:0] ctr_t;

  // --------------------------------------------------------------------------
  // configuration packet opcode, key bits 15:14
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    CFG_WRITE    = 2'd0,
    CFG_READ_CTR = 2'd1,
    CFG_RSVD2    = 2'd2,
    CFG_RSVD3    = 2'd3
  } cfg_op_e;

  // counter slots, also the index in a counter read
  typedef enum logic [1:0] {
    CTR_PER_OUT = 2'd0,
    CTR_CFG     = 2'd1,
    CTR_DROP    = 2'd2,
    CTR_ROUTED  = 2'd3
  } ctr_idx_e;

endpackage

//--- design/evt_mapper.sv
// one-entry stage; events taken while the link handshake is incomplete are lost, not queued
`include "hssl_macros.svh"

module evt_mapper
  import hssl_pkg::*;
(
  input  logic  pl_clk0_buf_int,
  input  logic  rst_n,
  input  logic  hs_complete,

  // incoming sensor event
  input  pld_t  evt_data,
  input  logic  evt_vld,
  output logic  evt_rdy,

  // mapper registers
  input  key_t  mp_key,
  input  pld_t  mp_fmsk [`HSSL_NUM_MREGS],
  input  fsft_t mp_fsft [`HSSL_NUM_MREGS],

  // routing key to the router
  output key_t  map_key,
  output logic  map_vld,
  input  logic  map_rdy
);

  key_t key_nxt;
  logic load;

  // key = mapper key | each masked field moved down
  always_comb
  begin
    key_nxt = mp_key;
    for (int i = 0; i < `HSSL_NUM_MREGS; i++)
    begin
      key_nxt = key_nxt | key_t'((evt_data & mp_fmsk[i]) >> mp_fsft[i]);
    end
  end

  // always ready without handshake, events are swallowed then
  assign evt_rdy = !hs_complete || !map_vld || map_rdy;
  assign load    = evt_vld && evt_rdy && hs_complete;

  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
      map_vld <= 1'b0;
    else if (load)
      map_vld <= 1'b1;
    else if (map_rdy)
      map_vld <= 1'b0;
  end

  // key register only changes on a load
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (load)
      map_key <= key_nxt;
  end

  // a stalled key must not move or vanish before the router takes it
  a_key_hold: assert property (
    @(posedge pl_clk0_buf_int) disable iff (!rst_n)
    map_vld && !map_rdy |=> map_vld && $stable(map_key)
  );

endmodule

//--- design/pkt_router.sv
// first matching table entry wins; drop_wait of 0 disables the back-pressure timeout
`include "hssl_macros.svh"

module pkt_router
  import hssl_pkg::*;
(
  input  logic   pl_clk0_buf_int,
  input  logic   rst_n,

  // mapped key from the mapper stage
  input  key_t   map_key,
  input  logic   map_vld,
  output logic   map_rdy,

  // routing table and timeout
  input  key_t   rt_tab_key   [`HSSL_NUM_RREGS],
  input  key_t   rt_tab_mask  [`HSSL_NUM_RREGS],
  input  route_t rt_tab_route [`HSSL_NUM_RREGS],
  input  ctr_t   drop_wait,

  // one stream per output channel
  output key_t   rt_key [`HSSL_NUM_CHANNELS],
  output logic   rt_vld [`HSSL_NUM_CHANNELS],
  input  logic   rt_rdy [`HSSL_NUM_CHANNELS],

  // counter pulses
  output logic   drop_pulse,
  output logic   routed_pulse
);

  logic   hit;
  route_t hit_rte;
  logic   out_vld;
  route_t out_ch;
  key_t   out_key;
  ctr_t   wait_ctr;
  logic   take;
  logic   stall;
  logic   timeout;
  logic   accept;

  // --------------------------------------------------------------------------
  // table lookup
  // --------------------------------------------------------------------------
  // scan from the top so the lowest entry ends up winning
  // entry key is compared unmasked, reset table of ones never hits
  always_comb
  begin
    hit     = 1'b0;
    hit_rte = '0;
    for (int i = `HSSL_NUM_RREGS - 1; i >= 0; i--)
    begin
      if ((map_key & rt_tab_mask[i]) == rt_tab_key[i])
      begin
        hit     = 1'b1;
        hit_rte = rt_tab_route[i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // output stage and timeout
  // --------------------------------------------------------------------------
  assign take    = out_vld && rt_rdy[out_ch];
  assign stall   = out_vld && !rt_rdy[out_ch];
  assign timeout = stall && (drop_wait != '0) && (wait_ctr == drop_wait);

  // free when empty or emptied this cycle
  // a timed-out slot frees one cycle later, so a miss never shares its drop pulse
  assign map_rdy = !out_vld || take;
  assign accept  = map_vld && map_rdy;

  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_vld      <= 1'b0;
      out_ch       <= '0;
      wait_ctr     <= '0;
      drop_pulse   <= 1'b0;
      routed_pulse <= 1'b0;
    end
    else
    begin
      // miss and timeout both count as drops
      drop_pulse   <= (accept && !hit) || timeout;
      routed_pulse <= take;

      if (accept)
      begin
        out_vld <= hit;
        out_ch  <= hit_rte;
      end
      else if (take || timeout)
        out_vld <= 1'b0;

      // count stalled cycles of the held packet
      if (stall && !timeout)
        wait_ctr <= wait_ctr + 1'b1;
      else
        wait_ctr <= '0;
    end
  end

  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (accept && hit)
      out_key <= map_key;
  end

  // steer the held packet to its channel
  always_comb
  begin
    for (int c = 0; c < `HSSL_NUM_CHANNELS; c++)
    begin
      rt_key[c] = out_key;
      rt_vld[c] = out_vld && (out_ch == route_t'(c));
    end
  end

  // a stalled packet keeps its channel and key until taken or timed out
  a_stall_hold: assert property (
    @(posedge pl_clk0_buf_int) disable iff (!rst_n)
    stall && !timeout |=> out_vld && $stable(out_ch) && $stable(out_key)
  );

endmodule

//--- design/ch0_arbiter.sv
// combinational merge for channel 0; a grant is held while tx0_rdy is low
module ch0_arbiter
  import hssl_pkg::*;
(
  input  logic pl_clk0_buf_int,
  input  logic rst_n,

  // routed packets, never carry a payload
  input  key_t rt_key,
  input  logic rt_vld,
  output logic rt_rdy,

  // counter read replies
  input  key_t rep_key,
  input  pld_t rep_pld,
  input  logic rep_vld,
  output logic rep_rdy,

  // channel 0 output
  output key_t tx0_key,
  output pld_t tx0_pld,
  output logic tx0_has_pld,
  output logic tx0_vld,
  input  logic tx0_rdy
);

  logic last_rep;
  logic lock;
  logic lock_rep;
  logic gnt_rep;

  // locked source first, then the one not served last
  always_comb
  begin
    if (lock)
      gnt_rep = lock_rep;
    else if (rt_vld && rep_vld)
      gnt_rep = !last_rep;
    else
      gnt_rep = rep_vld;
  end

  assign tx0_vld     = gnt_rep ? rep_vld : rt_vld;
  assign tx0_key     = gnt_rep ? rep_key : rt_key;
  assign tx0_pld     = gnt_rep ? rep_pld : '0;
  assign tx0_has_pld = gnt_rep;

  assign rt_rdy  = !gnt_rep && tx0_rdy;
  assign rep_rdy = gnt_rep && tx0_rdy;

  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      last_rep <= 1'b0;
      lock     <= 1'b0;
      lock_rep <= 1'b0;
    end
    else
    begin
      // lock clears if the router drops its packet
      lock     <= tx0_vld && !tx0_rdy;
      lock_rep <= gnt_rep;
      if (tx0_vld && tx0_rdy)
        last_rep <= gnt_rep;
    end
  end

  // a stalled output keeps its source and key unless the router dropped it
  a_grant_hold: assert property (
    @(posedge pl_clk0_buf_int) disable iff (!rst_n)
    tx0_vld && !tx0_rdy |=> !tx0_vld || ($stable(tx0_has_pld) && $stable(tx0_key))
  );

endmodule

//--- design/pkt_receiver.sv
// one reply in flight; reserved opcodes are counted as configuration packets and otherwise ignored
`include "hssl_macros.svh"

module pkt_receiver
  import hssl_pkg::*;
(
  input  logic       pl_clk0_buf_int,
  input  logic       rst_n,

  // packets from the link
  input  key_t       rx_key,
  input  pld_t       rx_pld,
  input  logic       rx_vld,
  output logic       rx_rdy,

  // register bank write port
  output logic       wr_en,
  output logic [7:0] wr_addr,
  output pld_t       wr_data,

  // counter values for replies
  input  key_t       reply_key,
  input  ctr_t       ctr [`HSSL_NUM_CREGS],

  // reply stream to channel 0
  output key_t       rep_key,
  output pld_t       rep_pld,
  output logic       rep_vld,
  input  logic       rep_rdy,

  // counter pulses
  output logic       cfg_pulse,
  output logic       per_pulse
);

  logic     accept;
  logic     is_cfg;
  cfg_op_e  op;
  ctr_idx_e idx;
  logic     do_write;
  logic     do_read;

  // --------------------------------------------------------------------------
  // decode
  // --------------------------------------------------------------------------
  assign is_cfg = (rx_key[31:16] == `HSSL_CFG_PREFIX);
  assign op     = cfg_op_e'(rx_key[15:14]);
  assign idx    = ctr_idx_e'(rx_key[1:0]);

  // stall the link only behind an untaken reply
  assign rx_rdy   = !rep_vld;
  assign accept   = rx_vld && rx_rdy;
  assign do_write = accept && is_cfg && (op == CFG_WRITE);
  assign do_read  = accept && is_cfg && (op == CFG_READ_CTR);

  // --------------------------------------------------------------------------
  // strobes and reply state
  // --------------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_en     <= 1'b0;
      rep_vld   <= 1'b0;
      cfg_pulse <= 1'b0;
      per_pulse <= 1'b0;
    end
    else
    begin
      wr_en     <= do_write;
      cfg_pulse <= accept && is_cfg;
      per_pulse <= accept && !is_cfg;

      // do_read implies no reply is pending
      if (do_read)
        rep_vld <= 1'b1;
      else if (rep_rdy)
        rep_vld <= 1'b0;
    end
  end

  // payload registers
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (do_write)
    begin
      wr_addr <= rx_key[7:0];
      wr_data <= rx_pld;
    end
    if (do_read)
    begin
      // counter index goes in the low key bits
      rep_key <= {reply_key[`HSSL_KEY_BITS - 1:2], idx};
      rep_pld <= pld_t'(ctr[idx]);
    end
  end

endmodule

//--- design/cfg_reg_bank.sv
// written only by configuration packets; unknown addresses are ignored and counters wrap
`include "hssl_macros.svh"

module cfg_reg_bank
  import hssl_pkg::*;
(
  input  logic       pl_clk0_buf_int,
  input  logic       rst_n,

  // write port from the receiver
  input  logic       wr_en,
  input  logic [7:0] wr_addr,
  input  pld_t       wr_data,

  // counter pulses
  input  logic       per_pulse,
  input  logic       cfg_pulse,
  input  logic       drop_pulse,
  input  logic       routed_pulse,

  // mapper registers
  output key_t       mp_key,
  output pld_t       mp_fmsk [`HSSL_NUM_MREGS],
  output fsft_t      mp_fsft [`HSSL_NUM_MREGS],

  // routing table
  output key_t       rt_tab_key   [`HSSL_NUM_RREGS],
  output key_t       rt_tab_mask  [`HSSL_NUM_RREGS],
  output route_t     rt_tab_route [`HSSL_NUM_RREGS],

  output ctr_t       drop_wait,
  output key_t       reply_key,
  output ctr_t       ctr [`HSSL_NUM_CREGS]
);

  logic [`HSSL_NUM_CREGS - 1:0] inc;

  // pulse per counter slot
  always_comb
  begin
    inc              = '0;
    inc[CTR_PER_OUT] = per_pulse;
    inc[CTR_CFG]     = cfg_pulse;
    inc[CTR_DROP]    = drop_pulse;
    inc[CTR_ROUTED]  = routed_pulse;
  end

  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mp_key    <= '0;
      drop_wait <= '0;
      reply_key <= '0;
      for (int i = 0; i < `HSSL_NUM_MREGS; i++)
      begin
        mp_fmsk[i] <= '0;
        mp_fsft[i] <= '0;
      end
      // all-ones keys with zero masks match nothing
      for (int i = 0; i < `HSSL_NUM_RREGS; i++)
      begin
        rt_tab_key[i]   <= '1;
        rt_tab_mask[i]  <= '0;
        rt_tab_route[i] <= '0;
      end
      for (int i = 0; i < `HSSL_NUM_CREGS; i++)
        ctr[i] <= '0;
    end
    else
    begin
      // ----------------------------------------------------------------------
      // register writes
      // ----------------------------------------------------------------------
      if (wr_en)
      begin
        if (wr_addr == `HSSL_REG_MP_KEY)
          mp_key <= key_t'(wr_data);
        if (wr_addr == `HSSL_REG_DROP_WAIT)
          drop_wait <= ctr_t'(wr_data);
        if (wr_addr == `HSSL_REG_REPLY_KEY)
          reply_key <= key_t'(wr_data);
        for (int i = 0; i < `HSSL_NUM_MREGS; i++)
        begin
          if (wr_addr == `HSSL_REG_MP_FMSK + 8'(i))
            mp_fmsk[i] <= wr_data;
          if (wr_addr == `HSSL_REG_MP_FSFT + 8'(i))
            mp_fsft[i] <= fsft_t'(wr_data);
        end
        for (int i = 0; i < `HSSL_NUM_RREGS; i++)
        begin
          if (wr_addr == `HSSL_REG_RT_KEY + 8'(i))
            rt_tab_key[i] <= key_t'(wr_data);
          if (wr_addr == `HSSL_REG_RT_MASK + 8'(i))
            rt_tab_mask[i] <= key_t'(wr_data);
          if (wr_addr == `HSSL_REG_RT_ROUTE + 8'(i))
            rt_tab_route[i] <= route_t'(wr_data);
        end
      end

      // counters step the cycle after their pulse
      for (int i = 0; i < `HSSL_NUM_CREGS; i++)
        ctr[i] <= ctr[i] + ctr_t'(inc[i]);
    end
  end

endmodule

//--- design/dvs_hssl_core.sv
// packet path only; the link transceiver and framing sit outside and supply hs_complete
`include "hssl_macros.svh"

module dvs_hssl_core
  import hssl_pkg::*;
(
  input  logic pl_clk0_buf_int,
  input  logic rst_n,
  input  logic hs_complete,

  // sensor events
  input  pld_t evt_data,
  input  logic evt_vld,
  output logic evt_rdy,

  // packets from the link
  input  key_t rx_key,
  input  pld_t rx_pld,
  input  logic rx_vld,
  output logic rx_rdy,

  // channel 0, routed and reply packets
  output key_t tx0_key,
  output pld_t tx0_pld,
  output logic tx0_has_pld,
  output logic tx0_vld,
  input  logic tx0_rdy,

  // channel 1, routed packets only
  output key_t tx1_key,
  output logic tx1_vld,
  input  logic tx1_rdy
);

  // --------------------------------------------------------------------------
  // internal signals
  // --------------------------------------------------------------------------
  key_t       mp_key_int;
  pld_t       mp_fmsk_int [`HSSL_NUM_MREGS];
  fsft_t      mp_fsft_int [`HSSL_NUM_MREGS];
  key_t       rt_tab_key_int   [`HSSL_NUM_RREGS];
  key_t       rt_tab_mask_int  [`HSSL_NUM_RREGS];
  route_t     rt_tab_route_int [`HSSL_NUM_RREGS];
  ctr_t       drop_wait_int;
  key_t       reply_key_int;
  ctr_t       ctr_int [`HSSL_NUM_CREGS];

  key_t       map_key_int;
  logic       map_vld_int;
  logic       map_rdy_int;

  key_t       rt_key_int [`HSSL_NUM_CHANNELS];
  logic       rt_vld_int [`HSSL_NUM_CHANNELS];
  logic       rt_rdy_int [`HSSL_NUM_CHANNELS];

  key_t       rep_key_int;
  pld_t       rep_pld_int;
  logic       rep_vld_int;
  logic       rep_rdy_int;

  logic       wr_en_int;
  logic [7:0] wr_addr_int;
  pld_t       wr_data_int;
  logic       drop_pulse_int;
  logic       routed_pulse_int;
  logic       cfg_pulse_int;
  logic       per_pulse_int;

  // channel 1 needs no arbitration
  assign tx1_key       = rt_key_int[1];
  assign tx1_vld       = rt_vld_int[1];
  assign rt_rdy_int[1] = tx1_rdy;

  // --------------------------------------------------------------------------
  // stream path: mapper, router, channel 0 merge
  // --------------------------------------------------------------------------
  evt_mapper evt_mapper_i (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .hs_complete     (hs_complete)
    , .evt_data        (evt_data)
    , .evt_vld         (evt_vld)
    , .evt_rdy         (evt_rdy)
    , .mp_key          (mp_key_int)
    , .mp_fmsk         (mp_fmsk_int)
    , .mp_fsft         (mp_fsft_int)
    , .map_key         (map_key_int)
    , .map_vld         (map_vld_int)
    , .map_rdy         (map_rdy_int)
    );

  pkt_router pkt_router_i (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .map_key         (map_key_int)
    , .map_vld         (map_vld_int)
    , .map_rdy         (map_rdy_int)
    , .rt_tab_key      (rt_tab_key_int)
    , .rt_tab_mask     (rt_tab_mask_int)
    , .rt_tab_route    (rt_tab_route_int)
    , .drop_wait       (drop_wait_int)
    , .rt_key          (rt_key_int)
    , .rt_vld          (rt_vld_int)
    , .rt_rdy          (rt_rdy_int)
    , .drop_pulse      (drop_pulse_int)
    , .routed_pulse    (routed_pulse_int)
    );

  ch0_arbiter ch0_arbiter_i (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .rt_key          (rt_key_int[0])
    , .rt_vld          (rt_vld_int[0])
    , .rt_rdy          (rt_rdy_int[0])
    , .rep_key         (rep_key_int)
    , .rep_pld         (rep_pld_int)
    , .rep_vld         (rep_vld_int)
    , .rep_rdy         (rep_rdy_int)
    , .tx0_key         (tx0_key)
    , .tx0_pld         (tx0_pld)
    , .tx0_has_pld     (tx0_has_pld)
    , .tx0_vld         (tx0_vld)
    , .tx0_rdy         (tx0_rdy)
    );

  // --------------------------------------------------------------------------
  // link receive side and registers
  // --------------------------------------------------------------------------
  pkt_receiver pkt_receiver_i (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .rx_key          (rx_key)
    , .rx_pld          (rx_pld)
    , .rx_vld          (rx_vld)
    , .rx_rdy          (rx_rdy)
    , .wr_en           (wr_en_int)
    , .wr_addr         (wr_addr_int)
    , .wr_data         (wr_data_int)
    , .reply_key       (reply_key_int)
    , .ctr             (ctr_int)
    , .rep_key         (rep_key_int)
    , .rep_pld         (rep_pld_int)
    , .rep_vld         (rep_vld_int)
    , .rep_rdy         (rep_rdy_int)
    , .cfg_pulse       (cfg_pulse_int)
    , .per_pulse       (per_pulse_int)
    );

  cfg_reg_bank cfg_reg_bank_i (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .wr_en           (wr_en_int)
    , .wr_addr         (wr_addr_int)
    , .wr_data         (wr_data_int)
    , .per_pulse       (per_pulse_int)
    , .cfg_pulse       (cfg_pulse_int)
    , .drop_pulse      (drop_pulse_int)
    , .routed_pulse    (routed_pulse_int)
    , .mp_key          (mp_key_int)
    , .mp_fmsk         (mp_fmsk_int)
    , .mp_fsft         (mp_fsft_int)
    , .rt_tab_key      (rt_tab_key_int)
    , .rt_tab_mask     (rt_tab_mask_int)
    , .rt_tab_route    (rt_tab_route_int)
    , .drop_wait       (drop_wait_int)
    , .reply_key       (reply_key_int)
    , .ctr             (ctr_int)
    );

endmodule

//--- test/tb_dvs_hssl_core.sv
// directed tests on one clock; counter reads wait a few idle cycles so earlier pulses have landed
`include "hssl_macros.svh"

module tb_dvs_hssl_core
  import hssl_pkg::*;
();

  localparam int WAIT_MAX = 64;
  // mapper setup used from test 2 on
  localparam key_t  MAP_KEY   = 32'h4000_0000;
  localparam key_t  MISS_KEY  = 32'h8000_0000;
  localparam pld_t  MAP_FMSK0 = 32'h0000_FF00;
  localparam fsft_t MAP_FSFT0 = 5'd8;
  localparam pld_t  MAP_FMSK1 = 32'h00FF_0000;
  localparam fsft_t MAP_FSFT1 = 5'd4;

  logic pl_clk0_buf_int;
  logic rst_n;
  logic hs_complete;
  pld_t evt_data;
  logic evt_vld;
  logic evt_rdy;
  key_t rx_key;
  pld_t rx_pld;
  logic rx_vld;
  logic rx_rdy;
  key_t tx0_key;
  pld_t tx0_pld;
  logic tx0_has_pld;
  logic tx0_vld;
  logic tx0_rdy;
  key_t tx1_key;
  logic tx1_vld;
  logic tx1_rdy;

  int          err_count;
  int          check_count;
  int          errs_at_start;
  string       test_name;
  logic [31:0] lcg_state;
  ctr_t        model_ctr [`HSSL_NUM_CREGS];
  key_t        model_reply_key;

  dvs_hssl_core dvs_hssl_core_i (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .hs_complete     (hs_complete)
    , .evt_data        (evt_data)
    , .evt_vld         (evt_vld)
    , .evt_rdy         (evt_rdy)
    , .rx_key          (rx_key)
    , .rx_pld          (rx_pld)
    , .rx_vld          (rx_vld)
    , .rx_rdy          (rx_rdy)
    , .tx0_key         (tx0_key)
    , .tx0_pld         (tx0_pld)
    , .tx0_has_pld     (tx0_has_pld)
    , .tx0_vld         (tx0_vld)
    , .tx0_rdy         (tx0_rdy)
    , .tx1_key         (tx1_key)
    , .tx1_vld         (tx1_vld)
    , .tx1_rdy         (tx1_rdy)
    );

  // period 4
  initial pl_clk0_buf_int = 1'b0;
  always #2 pl_clk0_buf_int = !pl_clk0_buf_int;

  // --------------------------------------------------------------------------
  // reference model and random data
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // key = base | (event & mask0) >> shift0 | (event & mask1) >> shift1
  function automatic key_t map_model(pld_t d, key_t base);
    return base | ((d & MAP_FMSK0) >> MAP_FSFT0) | ((d & MAP_FMSK1) >> MAP_FSFT1);
  endfunction

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_key(string what, key_t exp, key_t act);
    check_count++;
    if (exp !== act)
    begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_ctr(string what, ctr_t exp, ctr_t act);
    check_count++;
    if (exp !== act)
    begin
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    check_count++;
    if (exp !== act)
    begin
      $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic timeout_error(string what);
    $display("ERROR in %s: timed out waiting for %s", test_name, what);
    err_count++;
  endtask

  task automatic begin_test(string name);
    test_name     = name;
    errs_at_start = err_count;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", test_name, err_count - errs_at_start);
  endtask

  // --------------------------------------------------------------------------
  // drivers, all start and end 1 unit after a rising edge
  // --------------------------------------------------------------------------
  task automatic idle(int n);
    repeat (n) @(posedge pl_clk0_buf_int);
    #1;
  endtask

  task automatic send_rx(key_t k, pld_t p);
    int n;
    n      = 0;
    rx_key = k;
    rx_pld = p;
    rx_vld = 1'b1;
    @(negedge pl_clk0_buf_int);
    while (!rx_rdy && n < WAIT_MAX)
    begin
      @(negedge pl_clk0_buf_int);
      n++;
    end
    if (!rx_rdy)
      timeout_error("rx_rdy");
    @(posedge pl_clk0_buf_int);
    #1;
    rx_vld = 1'b0;
  endtask

  // write lands one cycle after acceptance
  task automatic send_cfg_write(logic [7:0] addr, pld_t data);
    send_rx({`HSSL_CFG_PREFIX, CFG_WRITE, 6'd0, addr}, data);
    model_ctr[CTR_CFG]++;
    idle(2);
  endtask

  task automatic send_ctr_read(ctr_idx_e idx);
    send_rx({`HSSL_CFG_PREFIX, CFG_READ_CTR, 12'd0, idx}, '0);
  endtask

  task automatic send_event(pld_t d);
    int n;
    n        = 0;
    evt_data = d;
    evt_vld  = 1'b1;
    @(negedge pl_clk0_buf_int);
    while (!evt_rdy && n < WAIT_MAX)
    begin
      @(negedge pl_clk0_buf_int);
      n++;
    end
    if (!evt_rdy)
      timeout_error("evt_rdy");
    @(posedge pl_clk0_buf_int);
    #1;
    evt_vld = 1'b0;
  endtask

  // ready only while collecting
  task automatic wait_tx0(output key_t k, output pld_t p, output logic f, output logic got);
    int n;
    n       = 0;
    got     = 1'b0;
    tx0_rdy = 1'b1;
    @(negedge pl_clk0_buf_int);
    while (!tx0_vld && n < WAIT_MAX)
    begin
      @(negedge pl_clk0_buf_int);
      n++;
    end
    if (!tx0_vld)
      timeout_error("tx0_vld");
    else
    begin
      k   = tx0_key;
      p   = tx0_pld;
      f   = tx0_has_pld;
      got = 1'b1;
    end
    @(posedge pl_clk0_buf_int);
    #1;
    tx0_rdy = 1'b0;
  endtask

  task automatic wait_tx1(output key_t k, output logic got);
    int n;
    n       = 0;
    got     = 1'b0;
    tx1_rdy = 1'b1;
    @(negedge pl_clk0_buf_int);
    while (!tx1_vld && n < WAIT_MAX)
    begin
      @(negedge pl_clk0_buf_int);
      n++;
    end
    if (!tx1_vld)
      timeout_error("tx1_vld");
    else
    begin
      k   = tx1_key;
      got = 1'b1;
    end
    @(posedge pl_clk0_buf_int);
    #1;
    tx1_rdy = 1'b0;
  endtask

  // counter read against the model, the read itself counts as config
  task automatic read_and_check(ctr_idx_e idx);
    key_t k;
    pld_t p;
    logic f;
    logic got;
    idle(4);
    send_ctr_read(idx);
    wait_tx0(k, p, f, got);
    if (got)
    begin
      check_key("reply key", {model_reply_key[31:2], idx}, k);
      check_ctr($sformatf("counter %0d", idx), model_ctr[idx], ctr_t'(p));
      check_flag("reply has_pld", 1'b1, f);
    end
    model_ctr[CTR_CFG]++;
  endtask

  // no tx valid over a short window
  task automatic expect_quiet(string what);
    logic seen;
    seen = 1'b0;
    repeat (10)
    begin
      @(negedge pl_clk0_buf_int);
      seen = seen | tx0_vld | tx1_vld;
    end
    @(posedge pl_clk0_buf_int);
    #1;
    check_flag(what, 1'b0, seen);
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  task automatic test_reset_state();
    begin_test("reset_state");
    @(negedge pl_clk0_buf_int);
    check_flag("tx0_vld after reset", 1'b0, tx0_vld);
    check_flag("tx1_vld after reset", 1'b0, tx1_vld);
    @(posedge pl_clk0_buf_int);
    #1;
    read_and_check(CTR_PER_OUT);
    read_and_check(CTR_DROP);
    read_and_check(CTR_ROUTED);
    // three reads so far
    read_and_check(CTR_CFG);
    end_test();
  endtask

  task automatic test_map_route();
    key_t k;
    logic got;
    pld_t d;
    begin_test("map_route");
    send_cfg_write(`HSSL_REG_REPLY_KEY, 32'h00C0_0100);
    model_reply_key = 32'h00C0_0100;
    send_cfg_write(`HSSL_REG_MP_KEY, MAP_KEY);
    send_cfg_write(`HSSL_REG_MP_FMSK, MAP_FMSK0);
    send_cfg_write(`HSSL_REG_MP_FMSK + 8'd1, MAP_FMSK1);
    send_cfg_write(`HSSL_REG_MP_FSFT, pld_t'(MAP_FSFT0));
    send_cfg_write(`HSSL_REG_MP_FSFT + 8'd1, pld_t'(MAP_FSFT1));
    // entry 0 takes every key with top nibble 4 to channel 1
    send_cfg_write(`HSSL_REG_RT_KEY, 32'h4000_0000);
    send_cfg_write(`HSSL_REG_RT_MASK, 32'hF000_0000);
    send_cfg_write(`HSSL_REG_RT_ROUTE, 32'd1);
    repeat (8)
    begin
      d = lcg_next();
      send_event(d);
      wait_tx1(k, got);
      if (got)
        check_key("tx1 key", map_model(d, MAP_KEY), k);
      model_ctr[CTR_ROUTED]++;
    end
    read_and_check(CTR_ROUTED);
    read_and_check(CTR_CFG);
    end_test();
  endtask

  task automatic test_misses();
    begin_test("misses");
    // top nibble 8 matches no entry
    send_cfg_write(`HSSL_REG_MP_KEY, MISS_KEY);
    repeat (4)
      send_event(lcg_next());
    model_ctr[CTR_DROP] += 4;
    expect_quiet("output on miss");
    read_and_check(CTR_DROP);
    send_cfg_write(`HSSL_REG_MP_KEY, MAP_KEY);
    // handshake down, events swallowed
    hs_complete = 1'b0;
    repeat (3)
      send_event(lcg_next());
    hs_complete = 1'b1;
    expect_quiet("output with handshake low");
    read_and_check(CTR_PER_OUT);
    read_and_check(CTR_DROP);
    read_and_check(CTR_ROUTED);
    end_test();
  endtask

  task automatic test_backpressure_drop();
    int   n;
    logic seen;
    begin_test("backpressure_drop");
    send_cfg_write(`HSSL_REG_DROP_WAIT, 32'd8);
    send_event(lcg_next());
    n = 0;
    @(negedge pl_clk0_buf_int);
    while (!tx1_vld && n < WAIT_MAX)
    begin
      @(negedge pl_clk0_buf_int);
      n++;
    end
    if (!tx1_vld)
      timeout_error("stalled packet on tx1");
    // held packet must time out
    n = 0;
    while (tx1_vld && n < WAIT_MAX)
    begin
      @(negedge pl_clk0_buf_int);
      n++;
    end
    if (tx1_vld)
      timeout_error("timeout drop on tx1");
    @(posedge pl_clk0_buf_int);
    #1;
    tx1_rdy = 1'b1;
    seen    = 1'b0;
    repeat (10)
    begin
      @(negedge pl_clk0_buf_int);
      seen = seen | tx1_vld;
    end
    @(posedge pl_clk0_buf_int);
    #1;
    tx1_rdy = 1'b0;
    check_flag("dropped packet reappeared", 1'b0, seen);
    model_ctr[CTR_DROP]++;
    read_and_check(CTR_DROP);
    end_test();
  endtask

  task automatic test_ch0_merge();
    key_t k;
    pld_t p;
    logic f;
    logic got;
    int   n_rt;
    int   n_rep;
    pld_t d;
    ctr_t exp_routed;
    begin_test("ch0_merge");
    send_cfg_write(`HSSL_REG_DROP_WAIT, 32'd0);
    send_cfg_write(`HSSL_REG_RT_ROUTE, 32'd0);
    idle(4);
    d = lcg_next();
    send_event(d);
    // reply carries the count from before this packet leaves
    exp_routed = model_ctr[CTR_ROUTED];
    send_ctr_read(CTR_ROUTED);
    model_ctr[CTR_CFG]++;
    idle(3);
    // link side stalls behind the untaken reply
    check_flag("rx_rdy with reply pending", 1'b0, rx_rdy);
    n_rt  = 0;
    n_rep = 0;
    repeat (2)
    begin
      wait_tx0(k, p, f, got);
      if (got && f)
      begin
        n_rep++;
        check_key("reply key", {model_reply_key[31:2], CTR_ROUTED}, k);
        check_ctr("reply payload", exp_routed, ctr_t'(p));
      end
      else if (got)
      begin
        n_rt++;
        check_key("routed key", map_model(d, MAP_KEY), k);
        check_flag("routed has_pld", 1'b0, f);
      end
    end
    check_ctr("routed packets on tx0", 1, n_rt);
    check_ctr("replies on tx0", 1, n_rep);
    tx0_rdy = 1'b1;
    expect_quiet("extra packet on tx0");
    tx0_rdy = 1'b0;
    model_ctr[CTR_ROUTED]++;
    send_cfg_write(`HSSL_REG_RT_ROUTE, 32'd1);
    read_and_check(CTR_ROUTED);
    end_test();
  endtask

  task automatic test_peripheral();
    begin_test("peripheral");
    for (int i = 0; i < 5; i++)
      send_rx(32'h1234_0000 + i, lcg_next());
    model_ctr[CTR_PER_OUT] += 5;
    expect_quiet("output on peripheral packet");
    read_and_check(CTR_PER_OUT);
    read_and_check(CTR_CFG);
    end_test();
  endtask

  // --------------------------------------------------------------------------
  // sequence
  // --------------------------------------------------------------------------
  initial
  begin
    rst_n       = 1'b0;
    hs_complete = 1'b0;
    evt_data    = '0;
    evt_vld     = 1'b0;
    rx_key      = '0;
    rx_pld      = '0;
    rx_vld      = 1'b0;
    tx0_rdy     = 1'b0;
    tx1_rdy     = 1'b0;
    err_count   = 0;
    check_count = 0;
    lcg_state   = 32'h718;
    model_reply_key = '0;
    for (int i = 0; i < `HSSL_NUM_CREGS; i++)
      model_ctr[i] = '0;
    repeat (3) @(posedge pl_clk0_buf_int);
    #1;
    rst_n       = 1'b1;
    hs_complete = 1'b1;
    test_reset_state();
    test_map_route();
    test_misses();
    test_backpressure_drop();
    test_ch0_merge();
    test_peripheral();
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // last resort against a stuck run
  initial
  begin
    #200000;
    $display("simulation ran past its time limit");
    $display("Checks failed");
    $finish;
  end

endmodule

//--- flist.f
+incdir+design
design/hssl_pkg.sv
design/evt_mapper.sv
design/pkt_router.sv
design/ch0_arbiter.sv
design/pkt_receiver.sv
design/cfg_reg_bank.sv
design/dvs_hssl_core.sv
test/tb_dvs_hssl_core.sv

//--- Bender.yml
package:
  name: dvs_hssl_core

sources:
  - include_dirs:
      - design
    files:
      - design/hssl_pkg.sv
      - design/evt_mapper.sv
      - design/pkt_router.sv
      - design/ch0_arbiter.sv
      - design/pkt_receiver.sv
      - design/cfg_reg_bank.sv
      - design/dvs_hssl_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_dvs_hssl_core.sv
